/* design/adc_capture_pkg.sv */
`default_nettype none

package adc_capture_pkg;

    // Every processed sample is this wide, whatever the converter width
    localparam int SAMPLE_WIDTH = 16;

    // Two's-complement, left-aligned sample
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // One decimated sample with its strobe
    typedef struct packed {
        logic    valid;  // One item this cycle
        sample_t data;   // Block mean
    } avg_sample_t;

    // Capture sequencer states
    typedef enum logic [1:0] {
        IDLE,    // Waiting for arm
        ARMED,   // Looking for a level crossing
        RECORD   // Writing samples into the buffer
    } trig_state_t;

endpackage

`default_nettype wire

/* design/adc_word_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_word_decode
    import adc_capture_pkg::*;
#(
    parameter int ADC_WIDTH = 12  // Raw converter width, 12 or 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 adc_valid,    // One raw word this cycle
    input  logic [ADC_WIDTH-1:0] adc_data,     // Offset-binary word
    output logic                 sample_valid, // One sample this cycle
    output sample_t              sample        // Signed, left-aligned
);

    // Pad needed to push the converter MSB up to bit 15
    localparam int ALIGN_SHIFT = SAMPLE_WIDTH - ADC_WIDTH;

    logic [ADC_WIDTH-1:0]    twos_word;  // Offset binary with MSB flipped
    logic [SAMPLE_WIDTH-1:0] wide_word;  // Zero-extended before alignment
    sample_t                 aligned;    // Final signed value

    // Offset binary to two's complement is just an MSB flip
    assign twos_word = {~adc_data[ADC_WIDTH-1], adc_data[ADC_WIDTH-2:0]};

    assign wide_word = SAMPLE_WIDTH'(twos_word);
    assign aligned   = sample_t'(wide_word << ALIGN_SHIFT); // Zeros fill the low bits

    // Strobe follows adc_valid by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= adc_valid;
        end
    end

    // Data register, holds the last word between strobes
    always_ff @(posedge clk) begin
        if (adc_valid) begin
            sample <= aligned;
        end
    end

endmodule

`default_nettype wire

/* design/sample_averager.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_averager
    import adc_capture_pkg::*;
#(
    parameter int AVG_SHIFT = 2  // Block length is 2**AVG_SHIFT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_valid, // One sample this cycle
    input  sample_t     sample,       // Decoded sample
    output avg_sample_t avg_out       // Decimated stream
);

    logic    avg_valid_q;  // One mean per block
    sample_t avg_data_q;   // Registered mean

    assign avg_out = '{valid: avg_valid_q, data: avg_data_q};

    if (AVG_SHIFT == 0) begin : g_bypass
        // Block of one, just a register stage
        always_ff @(posedge clk) begin
            if (reset) begin
                avg_valid_q <= 1'b0;
            end else begin
                avg_valid_q <= sample_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (sample_valid) begin
                avg_data_q <= sample;
            end
        end
    end else begin : g_boxcar
        // Sum of 2**AVG_SHIFT samples needs AVG_SHIFT guard bits
        localparam int ACC_WIDTH = SAMPLE_WIDTH + AVG_SHIFT;
        typedef logic signed [ACC_WIDTH-1:0] acc_t;

        logic [AVG_SHIFT-1:0] block_cnt;     // Position inside the block
        acc_t                 acc;           // Running sum of earlier samples
        acc_t                 acc_sum;       // Sum including this sample
        logic                 last_in_block; // This sample closes the block

        assign acc_sum       = acc + acc_t'(sample);  // Sign-extended add
        assign last_in_block = &block_cnt;

        // Phase counter and accumulator, both counted from reset
        always_ff @(posedge clk) begin
            if (reset) begin
                block_cnt   <= '0;
                acc         <= '0;
                avg_valid_q <= 1'b0;
            end else begin
                avg_valid_q <= sample_valid && last_in_block;
                if (sample_valid) begin
                    block_cnt <= block_cnt + 1'b1;            // Wraps at block end
                    acc       <= last_in_block ? '0 : acc_sum; // Restart on a new block
                end
            end
        end

        // Arithmetic shift gives the floor of the mean
        always_ff @(posedge clk) begin
            if (sample_valid && last_in_block) begin
                avg_data_q <= sample_t'(acc_sum >>> AVG_SHIFT);
            end
        end
    end

endmodule

`default_nettype wire

/* design/capture_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_trigger
    import adc_capture_pkg::*;
#(
    parameter int RECORD_LEN = 24  // Writes per trigger
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        arm,        // Pulse, only seen in IDLE
    input  sample_t     trig_level, // Signed threshold
    input  avg_sample_t avg_in,     // Averaged stream
    output logic        wr_en,      // One write this cycle
    output sample_t     wr_data,
    output logic        busy,       // ARMED or RECORD
    output logic        done        // Final write of a record
);

    localparam int CNT_W = $clog2(RECORD_LEN + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(RECORD_LEN - 1);

    trig_state_t      state;
    logic [CNT_W-1:0] rec_cnt;    // Writes issued so far in this record
    logic             level_hit;  // Current mean reaches the threshold
    logic             take;       // Forward this sample to the buffer

    assign level_hit = avg_in.data >= trig_level;  // Both signed

    // Qualifying sample in ARMED, or anything while recording
    always_comb begin
        take = 1'b0;
        if (avg_in.valid) begin
            case (state)
                ARMED:   take = level_hit;
                RECORD:  take = 1'b1;
                default: take = 1'b0;
            endcase
        end
    end

    assign busy = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            rec_cnt <= '0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end else begin
            wr_en <= take;
            done  <= 1'b0;
            case (state)
                IDLE: begin
                    rec_cnt <= '0;
                    if (arm) begin
                        state <= ARMED;
                    end
                end
                ARMED, RECORD: begin
                    if (take) begin
                        // Dropped writes in the FIFO still count here
                        if (rec_cnt == LAST_CNT) begin
                            state   <= IDLE;
                            rec_cnt <= '0;
                            done    <= 1'b1;
                        end else begin
                            state   <= RECORD;
                            rec_cnt <= rec_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Write data follows the strobe by the same single cycle
    always_ff @(posedge clk) begin
        if (take) begin
            wr_data <= avg_in.data;
        end
    end

endmodule

`default_nettype wire

/* design/sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
    import adc_capture_pkg::*;
#(
    parameter int FIFO_DEPTH = 16  // Power of two
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    wr_en,     // Write strobe, dropped when full
    input  sample_t wr_data,
    input  logic    rd_en,     // Read strobe, ignored when empty
    output sample_t rd_data,   // Registered, one cycle after rd_en
    output logic    empty,
    output logic    half_full, // More than half occupied
    output logic    full,
    output logic    overflow   // Sticky until reset
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;  // Extra bit so DEPTH fits

    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);
    localparam logic [CNT_W-1:0] HALF_CNT  = CNT_W'(FIFO_DEPTH / 2);

    sample_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;      // Wraps naturally at DEPTH
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             wr_accept;   // Write actually stored
    logic             rd_accept;   // Read actually performed

    assign wr_accept = wr_en && !full;
    assign rd_accept = rd_en && !empty;

    // Occupancy after this cycle, both strobes cancel out
    always_comb begin
        count_next = count;
        if (wr_accept && !rd_accept) begin
            count_next = count + 1'b1;
        end else if (rd_accept && !wr_accept) begin
            count_next = count - 1'b1;
        end
    end

    // Pointers, count and flags
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            empty     <= 1'b1;
            half_full <= 1'b0;
            full      <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count_next;
            // Flags from the next count so they change with it
            empty     <= (count_next == '0);
            half_full <= (count_next > HALF_CNT);
            full      <= (count_next == DEPTH_CNT);
            if (wr_en && full) begin
                overflow <= 1'b1;  // Sample lost, no way to stall the ADC
            end
        end
    end

    // Read port holds its value on an empty read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_accept) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* design/adc_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top
    import adc_capture_pkg::*;
#(
    parameter int ADC_WIDTH  = 12, // Raw word width
    parameter int AVG_SHIFT  = 2,  // log2 of block length
    parameter int RECORD_LEN = 24, // Samples per trigger
    parameter int FIFO_DEPTH = 16  // Power of two
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 adc_valid,
    input  logic [ADC_WIDTH-1:0] adc_data,
    input  logic                 arm,
    input  sample_t              trig_level,
    input  logic                 rd_en,
    output sample_t              rd_data,
    output logic                 empty,
    output logic                 half_full,
    output logic                 full,
    output logic                 overflow,
    output logic                 busy,
    output logic                 done
);

    logic        sample_valid;  // Decode to averager
    sample_t     sample;
    avg_sample_t avg_sample;    // Averager to trigger
    logic        wr_en;         // Trigger to FIFO
    sample_t     wr_data;

    // Offset binary to signed, left-aligned
    adc_word_decode #(
        .ADC_WIDTH (ADC_WIDTH)
    ) u_decode (
        .clk          (clk),
        .reset        (reset),
        .adc_valid    (adc_valid),
        .adc_data     (adc_data),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    // Boxcar decimation
    sample_averager #(
        .AVG_SHIFT (AVG_SHIFT)
    ) u_averager (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .avg_out      (avg_sample)
    );

    // Level trigger and record gate
    capture_trigger #(
        .RECORD_LEN (RECORD_LEN)
    ) u_trigger (
        .clk        (clk),
        .reset      (reset),
        .arm        (arm),
        .trig_level (trig_level),
        .avg_in     (avg_sample),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done)
    );

    // Host-side buffer
    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .empty     (empty),
        .half_full (half_full),
        .full      (full),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

/* verif/adc_capture_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_capture_asserts
    import adc_capture_pkg::*;
#(
    parameter int FIFO_DEPTH = 16  // Buffer depth, sets the pointer width
) (
    input logic                          clk,
    input logic                          reset,
    input logic                          full,    // FIFO flags
    input logic                          empty,
    input logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr,  // FIFO write pointer
    input logic                          wr_en,   // Trigger write strobe
    input logic                          done,
    input trig_state_t                   state
);

    int fail_cnt = 0;  // Failed properties so far

    // Occupancy cannot be 0 and DEPTH at once
    full_xor_empty: assert property (@(posedge clk) disable iff (reset) !(full && empty))
        else begin
            fail_cnt++;
            $error("FIFO flags full and empty together");
        end

    // A write arriving while full must leave the write pointer where it is
    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        full |=> $stable(wr_ptr))
        else begin
            fail_cnt++;
            $error("FIFO stored a write while full");
        end

    // done is registered on the RECORD to IDLE step
    done_on_exit: assert property (@(posedge clk) disable iff (reset)
        done |-> ($past(state) == RECORD && state == IDLE))
        else begin
            fail_cnt++;
            $error("done pulsed without leaving RECORD");
        end

    // Strobe lags the decision by a cycle
    no_write_from_idle: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> $past(state) != IDLE)
        else begin
            fail_cnt++;
            $error("trigger wrote a sample from IDLE");
        end

endmodule

bind adc_capture_top adc_capture_asserts #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_asserts (
    .clk    (clk),
    .reset  (reset),
    .full   (u_fifo.full),
    .empty  (u_fifo.empty),
    .wr_ptr (u_fifo.wr_ptr),
    .wr_en  (u_trigger.wr_en),
    .done   (u_trigger.done),
    .state  (u_trigger.state)
);

`default_nettype wire

/* verif/tb_adc_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture
    import adc_capture_pkg::*;
();

    localparam int ADC_WIDTH  = 12;
    localparam int AVG_SHIFT  = 2;
    localparam int RECORD_LEN = 24;
    localparam int FIFO_DEPTH = 16;
    localparam int CLK_NS     = 8;
    localparam int BLOCK      = 1 << AVG_SHIFT;
    localparam int MAX_RAND   = 400;  // Samples per random record before giving up
    // Per-test cycle estimates, random records at worst gap, plus margin
    localparam int RUN_CYCLES = 40 + 150 + 250 + 600 + 250 + 3 * (MAX_RAND * 4 + 100) + 500;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 adc_valid;
    logic [ADC_WIDTH-1:0] adc_data;
    logic                 arm;
    sample_t              trig_level;
    logic                 rd_en;
    sample_t              rd_data;
    logic                 empty;
    logic                 half_full;
    logic                 full;
    logic                 overflow;
    logic                 busy;
    logic                 done;

    sample_t     exp_q[$];     // What the host should read back, in order
    trig_state_t m_state;      // Model of the trigger
    sample_t     m_level;
    int          m_phase;
    int          m_acc;
    int          m_cnt;
    int          m_done;
    int          done_seen;
    int          rd_cnt;
    int          err_cnt;
    int          fail_tests;
    int          test_errs;
    logic        auto_read;
    logic        rand_read;
    logic        busy_watch;
    sample_t     first_rd;
    logic [31:0] rng = 32'hdbf6ef84;
    string       cur_test;

    adc_capture_top #(
        .ADC_WIDTH  (ADC_WIDTH),
        .AVG_SHIFT  (AVG_SHIFT),
        .RECORD_LEN (RECORD_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (.*);

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        $display("Timeout: tests still running after %0d cycles", RUN_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic complain(input string msg);
        err_cnt++;
        $display("Error in %s: %s", cur_test, msg);
    endtask

    // Decode, boxcar and trigger rules applied per raw word
    task automatic model_feed(input logic [ADC_WIDTH-1:0] word);
        sample_t s;
        sample_t mean;
        s = {~word[ADC_WIDTH-1], word[ADC_WIDTH-2:0], {(16 - ADC_WIDTH){1'b0}}};
        m_acc = m_acc + int'(s);
        m_phase++;
        if (m_phase == BLOCK) begin
            mean    = sample_t'(m_acc >>> AVG_SHIFT);  // Floor of the mean
            m_acc   = 0;
            m_phase = 0;
            if (m_state == RECORD || (m_state == ARMED && mean >= m_level)) begin
                exp_q.push_back(mean);
                m_cnt++;
                m_state = RECORD;
                if (m_cnt == RECORD_LEN) begin
                    m_state = IDLE;
                    m_cnt   = 0;
                    m_done++;
                end
            end
        end
    endtask

    // One clock; checks reads from the last cycle, then drives defaults
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        #1;
        if (done) done_seen++;
        if (rd_en) begin
            if (exp_q.size() == 0) begin
                complain("FIFO returned a sample the model never produced");
            end else begin
                if (rd_cnt == 0) first_rd = rd_data;
                rd_cnt++;
                compare("rd_data", exp_q.pop_front(), rd_data);
            end
        end
        if (busy_watch) begin
            compare("busy", !done, busy);  // Drops together with done
            busy_watch = !done;
        end
        r         = rand32();
        adc_valid = 1'b0;
        arm       = 1'b0;
        rd_en     = auto_read && !empty && (!rand_read || r[1:0] != 2'b00);
    endtask

    task automatic feed(input logic [ADC_WIDTH-1:0] word, input int gap);
        adc_valid = 1'b1;
        adc_data  = word;
        model_feed(word);
        tick();
        repeat (gap) tick();
    endtask

    task automatic do_arm(input sample_t level);
        trig_level = level;  // Held until the next arm
        arm        = 1'b1;
        if (m_state == IDLE) begin
            m_state = ARMED;
            m_level = level;
        end
        tick();
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (done_seen < m_done && n < limit) begin
            tick();
            n++;
        end
        if (done_seen != m_done) complain("done pulse count does not match the model");
    endtask

    // Host reads until model and FIFO are both empty
    task automatic drain(input int limit);
        int n;
        n = 0;
        auto_read = 1'b1;
        while ((exp_q.size() != 0 || !empty) && n < limit) begin
            tick();
            n++;
        end
        if (exp_q.size() != 0) complain("FIFO ran dry before all expected samples came out");
    endtask

    task automatic apply_reset();
        reset      = 1'b1;
        adc_valid  = 1'b0;
        adc_data   = '0;
        arm        = 1'b0;
        trig_level = '0;
        rd_en      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        exp_q.delete();
        m_state    = IDLE;
        m_phase    = 0;  // Block phase restarts with the DUT
        m_acc      = 0;
        m_cnt      = 0;
        m_done     = 0;
        done_seen  = 0;
        rd_cnt     = 0;
        auto_read  = 1'b0;
        rand_read  = 1'b0;
        busy_watch = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = err_cnt;
        apply_reset();
    endtask

    task automatic finish_test();
        if (err_cnt == test_errs) begin
            $display("%s: ok", cur_test);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", cur_test, err_cnt - test_errs);
        end
    endtask

    task automatic reset_values();
        start_test("reset_values");
        compare("empty", 1, empty);
        compare("full", 0, full);
        compare("half_full", 0, half_full);
        compare("overflow", 0, overflow);
        compare("busy", 0, busy);
        compare("done", 0, done);
        compare("rd_data", 0, rd_data);
        finish_test();
    endtask

    task automatic decode_and_average();
        logic [ADC_WIDTH-1:0] words[32] = '{
            12'h000, 12'h001, 12'h002, 12'h003, 12'h000, 12'hfff, 12'h001, 12'hffe,
            12'h7ff, 12'h800, 12'h801, 12'h7fe, 12'h7ff, 12'h7ff, 12'h800, 12'h7ff,
            12'hfff, 12'hffe, 12'hffd, 12'hffc, 12'hfff, 12'hfff, 12'hfff, 12'hfff,
            12'h001, 12'h003, 12'h7fd, 12'h802, 12'h123, 12'habc, 12'h456, 12'hdef};
        start_test("decode_average");
        do_arm(16'sh8000);  // Lowest level, every mean passes
        foreach (words[i]) feed(words[i], 0);
        repeat (6) tick();
        drain(100);
        compare("reads", 32 / BLOCK, rd_cnt);
        finish_test();
    endtask

    task automatic level_threshold();
        start_test("threshold");
        auto_read = 1'b1;
        do_arm(16'sh1000);  // Equals the decode of raw 0x900
        busy_watch = 1'b1;
        for (int b = 0; b < 8; b++) begin
            repeat (BLOCK) feed(12'h700 + 12'(b * 64), 0);  // Means below the level
        end
        repeat (6) tick();
        compare("empty before level", 1, empty);
        for (int b = 8; b < 32; b++) begin
            repeat (BLOCK) feed(12'h700 + 12'(b * 64), 0);
        end
        wait_done(50);
        drain(100);
        compare("first read", 16'sh1000, first_rd);
        compare("reads", RECORD_LEN, rd_cnt);
        finish_test();
    endtask

    task automatic record_and_rearm();
        start_test("record_rearm");
        auto_read = 1'b1;
        do_arm(16'sh8000);
        for (int i = 0; i < RECORD_LEN * BLOCK; i++) feed(12'(i * 37), 0);
        wait_done(50);
        compare("done count", 1, done_seen);
        for (int i = 0; i < 4 * BLOCK; i++) feed(12'(i * 53), 0);  // Not armed
        repeat (6) tick();
        compare("empty while idle", 1, empty);
        drain(100);
        compare("reads", RECORD_LEN, rd_cnt);
        do_arm(16'sh8000);
        for (int i = 0; i < RECORD_LEN * BLOCK; i++) feed(12'(i * 29 + 5), 0);
        wait_done(50);
        drain(100);
        compare("done count", 2, done_seen);
        compare("reads", 2 * RECORD_LEN, rd_cnt);
        compare("overflow", 0, overflow);
        finish_test();
    endtask

    task automatic flags_and_overflow();
        start_test("flags_overflow");
        do_arm(16'sh8000);
        for (int i = 0; i < RECORD_LEN * BLOCK; i++) feed(12'(i * 91), 0);
        wait_done(50);
        repeat (2) tick();
        while (exp_q.size() > FIFO_DEPTH) void'(exp_q.pop_back());  // Lost when full
        compare("full", 1, full);
        compare("overflow", 1, overflow);
        compare("half_full", 1, half_full);
        compare("empty", 0, empty);
        for (int n = FIFO_DEPTH - 1; n >= 0; n--) begin
            rd_en = 1'b1;
            tick();
            compare("empty", n == 0, empty);
            compare("half_full", n > FIFO_DEPTH / 2, half_full);
            compare("full", 0, full);
        end
        compare("reads", FIFO_DEPTH, rd_cnt);
        finish_test();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        int          n;
        start_test("random_stream");
        auto_read = 1'b1;
        rand_read = 1'b1;
        for (int rec = 0; rec < 3; rec++) begin
            n = 0;
            do_arm(sample_t'(rand32()) >>> 2);  // Level within a quarter of full scale
            while (m_state != IDLE && n < MAX_RAND) begin
                r = rand32();
                feed(r[11:0], int'(r[13:12]));
                n++;
            end
            if (m_state != IDLE) complain("random record never completed in the model");
            wait_done(50);
        end
        repeat (6) tick();
        drain(200);
        compare("done count", 3, done_seen);
        compare("overflow", 0, overflow);
        finish_test();
    endtask

    initial begin
        err_cnt    = 0;
        fail_tests = 0;
        reset_values();
        decode_and_average();
        level_threshold();
        record_and_rearm();
        flags_and_overflow();
        random_stream();
        err_cnt += UUT.u_asserts.fail_cnt;  // Properties of the bound checker
        $display("6 tests run, %0d failed, %0d errors", fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/adc_capture_pkg.sv
design/adc_word_decode.sv
design/sample_averager.sv
design/capture_trigger.sv
design/sample_fifo.sv
design/adc_capture_top.sv
verif/adc_capture_asserts.sv
verif/tb_adc_capture.sv

/* Makefile */
TOP := tb_adc_capture
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || grep -q '%Error' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
